//--- verilog/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    localparam int XLEN       = 32;  // Word and register width.
    localparam int OP_W       = 6;
    localparam int FUNCT_W    = 6;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;
    localparam int JINDEX_W   = 26;

    // Field positions within the instruction word.
    localparam int OP_LSB    = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;

    localparam logic [XLEN-1:0]       HALT_WORD = '1;
    localparam logic [REG_ADDR_W-1:0] LINK_REG  = 5'd31;  // Written by JAL.

    typedef enum logic [OP_W-1:0] {
        OP_SPECIAL = 6'd0,
        OP_J       = 6'd2,
        OP_JAL     = 6'd3,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_LUI     = 6'd15
    } opcode_e;

    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_JALR = 6'd9,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42
    } funct_e;

endpackage

`default_nettype wire

//--- verilog/mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_JR,
        BR_JALR,
        BR_BEQ,
        BR_BNE,
        BR_J,
        BR_JAL
    } branch_e;

    typedef struct packed {
        logic                                 valid;
        logic                                 halt;
        alu_op_e                              alu_op;
        branch_e                              branch;
        logic [mips_isa_pkg::REG_ADDR_W-1:0]  rs;
        logic [mips_isa_pkg::REG_ADDR_W-1:0]  rt;
        logic [mips_isa_pkg::REG_ADDR_W-1:0]  dest;
        logic                                 wr_en;
        logic                                 use_imm;
        logic [mips_isa_pkg::XLEN-1:0]        imm;  // Already extended.
        logic [mips_isa_pkg::SHAMT_W-1:0]     shamt;
        logic [mips_isa_pkg::JINDEX_W-1:0]    jindex;
    } decoded_t;

    typedef struct packed {
        logic                                 valid;
        logic                                 halt;
        branch_e                              branch;
        logic                                 taken;
        logic                                 wr_en;
        logic [mips_isa_pkg::REG_ADDR_W-1:0]  dest;
        logic [mips_isa_pkg::XLEN-1:0]        value;
        logic [mips_isa_pkg::XLEN-1:0]        reg_target;  // rs for JR and JALR.
        logic [mips_isa_pkg::IMM_W-1:0]       imm;
        logic [mips_isa_pkg::JINDEX_W-1:0]    jindex;
    } exec_t;

    typedef struct packed {
        logic [mips_isa_pkg::XLEN-1:0]        pc;
        logic                                 wr_en;
        logic [mips_isa_pkg::REG_ADDR_W-1:0]  wr_addr;
        logic [mips_isa_pkg::XLEN-1:0]        wr_data;
    } retire_t;

endpackage

`default_nettype wire

//--- verilog/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder
(
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic                            i_instr_valid,
    input  logic [mips_isa_pkg::XLEN-1:0]   i_instr,
    output mips_pipe_pkg::decoded_t         o_decoded
);

    mips_isa_pkg::opcode_e                 opcode;
    mips_isa_pkg::funct_e                  funct;
    logic [mips_isa_pkg::IMM_W-1:0]        imm_raw;
    logic [mips_isa_pkg::XLEN-1:0]         imm_zext;
    logic                                  accept;
    logic                                  halted_q;
    logic                                  valid_q;
    mips_pipe_pkg::decoded_t               dec_d;
    mips_pipe_pkg::decoded_t               dec_q;

    assign opcode   = mips_isa_pkg::opcode_e'(i_instr[mips_isa_pkg::OP_LSB +: mips_isa_pkg::OP_W]);
    assign funct    = mips_isa_pkg::funct_e'(i_instr[mips_isa_pkg::FUNCT_W-1:0]);
    assign imm_raw  = i_instr[mips_isa_pkg::IMM_W-1:0];
    assign imm_zext = {{(mips_isa_pkg::XLEN - mips_isa_pkg::IMM_W){1'b0}}, imm_raw};
    assign accept   = i_instr_valid && !halted_q;  // Nothing taken after HALT.

    //////////////////////////////////////////////////////////////////////
    // Field split and classification
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        dec_d        = '0;
        dec_d.valid  = accept;
        dec_d.rs     = i_instr[mips_isa_pkg::RS_LSB +: mips_isa_pkg::REG_ADDR_W];
        dec_d.rt     = i_instr[mips_isa_pkg::RT_LSB +: mips_isa_pkg::REG_ADDR_W];
        dec_d.dest   = i_instr[mips_isa_pkg::RD_LSB +: mips_isa_pkg::REG_ADDR_W];
        dec_d.imm    = {{(mips_isa_pkg::XLEN - mips_isa_pkg::IMM_W){imm_raw[15]}}, imm_raw};
        dec_d.shamt  = i_instr[mips_isa_pkg::SHAMT_LSB +: mips_isa_pkg::SHAMT_W];
        dec_d.jindex = i_instr[mips_isa_pkg::JINDEX_W-1:0];
        if (i_instr == mips_isa_pkg::HALT_WORD)
        begin
            dec_d.halt = 1'b1;
        end
        else
        begin
            case (opcode)
                mips_isa_pkg::OP_SPECIAL:
                begin
                    case (funct)
                        mips_isa_pkg::FN_SLL:  dec_d.alu_op = mips_pipe_pkg::ALU_SLL;
                        mips_isa_pkg::FN_SRL:  dec_d.alu_op = mips_pipe_pkg::ALU_SRL;
                        mips_isa_pkg::FN_SRA:  dec_d.alu_op = mips_pipe_pkg::ALU_SRA;
                        mips_isa_pkg::FN_ADDU: dec_d.alu_op = mips_pipe_pkg::ALU_ADD;
                        mips_isa_pkg::FN_SUBU: dec_d.alu_op = mips_pipe_pkg::ALU_SUB;
                        mips_isa_pkg::FN_AND:  dec_d.alu_op = mips_pipe_pkg::ALU_AND;
                        mips_isa_pkg::FN_OR:   dec_d.alu_op = mips_pipe_pkg::ALU_OR;
                        mips_isa_pkg::FN_XOR:  dec_d.alu_op = mips_pipe_pkg::ALU_XOR;
                        mips_isa_pkg::FN_SLT:  dec_d.alu_op = mips_pipe_pkg::ALU_SLT;
                        mips_isa_pkg::FN_JR:   dec_d.branch = mips_pipe_pkg::BR_JR;
                        mips_isa_pkg::FN_JALR: dec_d.branch = mips_pipe_pkg::BR_JALR;
                        default: ;  // Unknown function, no-op.
                    endcase
                    dec_d.wr_en = (dec_d.alu_op != mips_pipe_pkg::ALU_NOP) ||
                                  (dec_d.branch == mips_pipe_pkg::BR_JALR);
                end
                mips_isa_pkg::OP_J:     dec_d.branch = mips_pipe_pkg::BR_J;
                mips_isa_pkg::OP_JAL:
                begin
                    dec_d.branch = mips_pipe_pkg::BR_JAL;
                    dec_d.dest   = mips_isa_pkg::LINK_REG;
                    dec_d.wr_en  = 1'b1;
                end
                mips_isa_pkg::OP_BEQ:   dec_d.branch = mips_pipe_pkg::BR_BEQ;
                mips_isa_pkg::OP_BNE:   dec_d.branch = mips_pipe_pkg::BR_BNE;
                mips_isa_pkg::OP_ADDIU: dec_d.alu_op = mips_pipe_pkg::ALU_ADD;
                mips_isa_pkg::OP_SLTI:  dec_d.alu_op = mips_pipe_pkg::ALU_SLT;
                mips_isa_pkg::OP_ANDI:
                begin
                    dec_d.alu_op = mips_pipe_pkg::ALU_AND;
                    dec_d.imm    = imm_zext;
                end
                mips_isa_pkg::OP_ORI:
                begin
                    dec_d.alu_op = mips_pipe_pkg::ALU_OR;
                    dec_d.imm    = imm_zext;
                end
                mips_isa_pkg::OP_LUI:   dec_d.alu_op = mips_pipe_pkg::ALU_LUI;
                default: ;
            endcase
            // I-type arithmetic writes rt.
            if (opcode != mips_isa_pkg::OP_SPECIAL && dec_d.alu_op != mips_pipe_pkg::ALU_NOP)
            begin
                dec_d.use_imm = 1'b1;
                dec_d.dest    = dec_d.rt;
                dec_d.wr_en   = 1'b1;
            end
        end
        if (dec_d.dest == '0)
        begin
            dec_d.wr_en = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            halted_q <= 1'b0;
            valid_q  <= 1'b0;
        end
        else
        begin
            valid_q <= accept;
            if (accept && dec_d.halt)
            begin
                halted_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        dec_q <= dec_d;
    end

    always_comb
    begin
        o_decoded       = dec_q;
        o_decoded.valid = valid_q;
    end

endmodule

`default_nettype wire

//--- verilog/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit
(
    input  logic                                  i_clk,
    input  logic                                  i_arst_n,
    input  mips_pipe_pkg::decoded_t               i_decoded,
    output logic [mips_isa_pkg::REG_ADDR_W-1:0]   o_rs_addr,
    output logic [mips_isa_pkg::REG_ADDR_W-1:0]   o_rt_addr,
    input  logic [mips_isa_pkg::XLEN-1:0]         i_rs_data,
    input  logic [mips_isa_pkg::XLEN-1:0]         i_rt_data,
    output mips_pipe_pkg::exec_t                  o_exec
);

    logic                                  fwd_rs;
    logic                                  fwd_rt;
    logic [mips_isa_pkg::XLEN-1:0]         rs_val;
    logic [mips_isa_pkg::XLEN-1:0]         rt_val;
    logic [mips_isa_pkg::XLEN-1:0]         op_b;
    logic [mips_isa_pkg::XLEN-1:0]         alu_res;
    logic                                  taken;
    logic                                  valid_q;
    mips_pipe_pkg::exec_t                  ex_d;
    mips_pipe_pkg::exec_t                  ex_q;

    assign o_rs_addr = i_decoded.rs;
    assign o_rt_addr = i_decoded.rt;

    // Instruction just ahead is still in the output register.
    assign fwd_rs = o_exec.valid && o_exec.wr_en && (o_exec.dest != '0) &&
                    (o_exec.dest == i_decoded.rs);
    assign fwd_rt = o_exec.valid && o_exec.wr_en && (o_exec.dest != '0) &&
                    (o_exec.dest == i_decoded.rt);

    assign rs_val = fwd_rs ? o_exec.value : i_rs_data;
    assign rt_val = fwd_rt ? o_exec.value : i_rt_data;
    assign op_b   = i_decoded.use_imm ? i_decoded.imm : rt_val;

    //////////////////////////////////////////////////////////////////////
    // ALU and branch condition
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (i_decoded.alu_op)
            mips_pipe_pkg::ALU_ADD: alu_res = rs_val + op_b;
            mips_pipe_pkg::ALU_SUB: alu_res = rs_val - op_b;
            mips_pipe_pkg::ALU_AND: alu_res = rs_val & op_b;
            mips_pipe_pkg::ALU_OR:  alu_res = rs_val | op_b;
            mips_pipe_pkg::ALU_XOR: alu_res = rs_val ^ op_b;
            mips_pipe_pkg::ALU_SLT: alu_res = {31'd0, $signed(rs_val) < $signed(op_b)};
            mips_pipe_pkg::ALU_SLL: alu_res = rt_val << i_decoded.shamt;
            mips_pipe_pkg::ALU_SRL: alu_res = rt_val >> i_decoded.shamt;
            mips_pipe_pkg::ALU_SRA: alu_res = $signed(rt_val) >>> i_decoded.shamt;
            mips_pipe_pkg::ALU_LUI: alu_res = {i_decoded.imm[mips_isa_pkg::IMM_W-1:0], 16'd0};
            default:                alu_res = '0;
        endcase
    end

    always_comb
    begin
        case (i_decoded.branch)
            mips_pipe_pkg::BR_NONE: taken = 1'b0;
            mips_pipe_pkg::BR_BEQ:  taken = (rs_val == rt_val);
            mips_pipe_pkg::BR_BNE:  taken = (rs_val != rt_val);
            default:                taken = 1'b1;  // Jumps always taken.
        endcase
    end

    always_comb
    begin
        ex_d.valid      = i_decoded.valid;
        ex_d.halt       = i_decoded.halt;
        ex_d.branch     = i_decoded.branch;
        ex_d.taken      = taken;
        ex_d.wr_en      = i_decoded.wr_en;
        ex_d.dest       = i_decoded.dest;
        ex_d.value      = alu_res;
        ex_d.reg_target = rs_val;
        ex_d.imm        = i_decoded.imm[mips_isa_pkg::IMM_W-1:0];
        ex_d.jindex     = i_decoded.jindex;
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= i_decoded.valid;
        end
    end

    always_ff @(posedge i_clk)
    begin
        ex_q <= ex_d;
    end

    always_comb
    begin
        o_exec       = ex_q;
        o_exec.valid = valid_q;
    end

endmodule

`default_nettype wire

//--- verilog/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage
#(
    parameter logic [mips_isa_pkg::XLEN-1:0] RESET_PC = '0
)
(
    input  logic                                  i_clk,
    input  logic                                  i_arst_n,
    input  mips_pipe_pkg::exec_t                  i_exec,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0]   i_rs_addr,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0]   i_rt_addr,
    output logic [mips_isa_pkg::XLEN-1:0]         o_rs_data,
    output logic [mips_isa_pkg::XLEN-1:0]         o_rt_data,
    output logic                                  o_retire,
    output mips_pipe_pkg::retire_t                o_retire_info,
    output logic [mips_isa_pkg::XLEN-1:0]         o_pc,
    output logic                                  o_halted
);

    localparam int NUM_REGS = 2 ** mips_isa_pkg::REG_ADDR_W;

    logic [mips_isa_pkg::XLEN-1:0]   regs [NUM_REGS];
    logic [mips_isa_pkg::XLEN-1:0]   pc_q;
    logic [mips_isa_pkg::XLEN-1:0]   pc_plus4;
    logic [mips_isa_pkg::XLEN-1:0]   br_offset;
    logic [mips_isa_pkg::XLEN-1:0]   next_pc;
    logic [mips_isa_pkg::XLEN-1:0]   wr_data;
    logic                            is_link;
    logic                            wr_en;

    assign o_rs_data = (i_rs_addr == '0) ? '0 : regs[i_rs_addr];  // r0 reads zero.
    assign o_rt_data = (i_rt_addr == '0) ? '0 : regs[i_rt_addr];

    assign pc_plus4  = pc_q + 32'd4;
    assign br_offset = {{14{i_exec.imm[mips_isa_pkg::IMM_W-1]}}, i_exec.imm, 2'b00};
    assign is_link   = (i_exec.branch == mips_pipe_pkg::BR_JAL) ||
                       (i_exec.branch == mips_pipe_pkg::BR_JALR);
    assign wr_en     = i_exec.valid && i_exec.wr_en;
    assign wr_data   = is_link ? pc_plus4 : i_exec.value;
    assign o_pc      = pc_q;

    //////////////////////////////////////////////////////////////////////
    // Next PC
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        next_pc = pc_plus4;
        if (i_exec.taken)
        begin
            case (i_exec.branch)
                mips_pipe_pkg::BR_BEQ,
                mips_pipe_pkg::BR_BNE:  next_pc = pc_plus4 + br_offset;
                mips_pipe_pkg::BR_J,
                mips_pipe_pkg::BR_JAL:  next_pc = {pc_plus4[31:28], i_exec.jindex, 2'b00};
                mips_pipe_pkg::BR_JR,
                mips_pipe_pkg::BR_JALR: next_pc = i_exec.reg_target;
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
            pc_q     <= RESET_PC;
            o_retire <= 1'b0;
            o_halted <= 1'b0;
        end
        else
        begin
            o_retire <= i_exec.valid;
            if (i_exec.valid)
            begin
                pc_q <= next_pc;
                if (i_exec.halt)
                begin
                    o_halted <= 1'b1;
                end
            end
            if (wr_en)
            begin
                regs[i_exec.dest] <= wr_data;
            end
        end
    end

    // Retire report, zeroed fields when nothing is written.
    always_ff @(posedge i_clk)
    begin
        if (i_exec.valid)
        begin
            o_retire_info.pc      <= pc_q;
            o_retire_info.wr_en   <= wr_en;
            o_retire_info.wr_addr <= wr_en ? i_exec.dest : '0;
            o_retire_info.wr_data <= wr_en ? wr_data : '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core
#(
    parameter logic [mips_isa_pkg::XLEN-1:0] RESET_PC = '0
)
(
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic                            i_instr_valid,
    input  logic [mips_isa_pkg::XLEN-1:0]   i_instr,
    output logic                            o_retire,
    output mips_pipe_pkg::retire_t          o_retire_info,
    output logic [mips_isa_pkg::XLEN-1:0]   o_pc,
    output logic                            o_halted
);

    mips_pipe_pkg::decoded_t                 decoded;
    mips_pipe_pkg::exec_t                    exec;
    logic [mips_isa_pkg::REG_ADDR_W-1:0]     rs_addr;
    logic [mips_isa_pkg::REG_ADDR_W-1:0]     rt_addr;
    logic [mips_isa_pkg::XLEN-1:0]           rs_data;
    logic [mips_isa_pkg::XLEN-1:0]           rt_data;

    //////////////////////////////////////////////////////////////////////
    // Decode, execute, result
    //////////////////////////////////////////////////////////////////////

    decoder decoder0
    (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_decoded     (decoded)
    );

    execute_unit execute_unit0
    (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_decoded (decoded),
        .o_rs_addr (rs_addr),
        .o_rt_addr (rt_addr),
        .i_rs_data (rs_data),
        .i_rt_data (rt_data),
        .o_exec    (exec)
    );

    result_stage
    #(
        .RESET_PC (RESET_PC)
    )
    result_stage0
    (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_exec        (exec),
        .i_rs_addr     (rs_addr),
        .i_rt_addr     (rt_addr),
        .o_rs_data     (rs_data),
        .o_rt_data     (rt_data),
        .o_retire      (o_retire),
        .o_retire_info (o_retire_info),
        .o_pc          (o_pc),
        .o_halted      (o_halted)
    );

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen
#(
    parameter int CLK_PERIOD   = 20,
    parameter int RESET_CYCLES = 3
)
(
    output logic o_clk,
    output logic o_arst_n
);

    initial
    begin
        o_clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) o_clk = ~o_clk;
        end
    end

    initial
    begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);  // Release away from the active edge.
        o_arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/mips_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb;

    localparam logic [31:0] RESET_PC    = 32'h0040_0000;
    localparam int          NUM_INSTR   = 400;
    localparam int          CYCLE_LIMIT = NUM_INSTR * 4 + 400;  // About four per instruction.

    typedef struct packed {
        mips_pipe_pkg::retire_t info;
        logic [31:0]            next_pc;
        logic                   halt;
    } expect_t;

    logic                    clk;
    logic                    arst_n;
    logic                    instr_valid;
    logic [31:0]             instr;
    logic                    retire;
    mips_pipe_pkg::retire_t  retire_info;
    logic [31:0]             pc;
    logic                    halted;

    logic [15:0]             lfsr_state = 16'd53;
    logic [31:0]             model_regs [32];
    logic [31:0]             model_pc;
    logic [4:0]              link_reg;  // Destination of the last issued link or zero.
    expect_t                 expected [$];
    expect_t                 head;
    logic [31:0]             draw;
    int                      issued;
    int                      idx;
    int                      cycle_count = 0;

    clock_gen
    #(
        .CLK_PERIOD   (20),
        .RESET_CYCLES (3)
    )
    clock_gen0
    (
        .o_clk    (clk),
        .o_arst_n (arst_n)
    );

    mips_core
    #(
        .RESET_PC (RESET_PC)
    )
    dut0
    (
        .i_clk         (clk),
        .i_arst_n      (arst_n),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .o_retire      (retire),
        .o_retire_info (retire_info),
        .o_pc          (pc),
        .o_halted      (halted)
    );

    //////////////////////////////////////////////////////////////////////
    // Random source and checks
    //////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Two's complement order from the sign bits, then the magnitude.
    function automatic logic less_signed(input logic [31:0] x, input logic [31:0] y);
        if (x[31] != y[31])
        begin
            return x[31];
        end
        else
        begin
            return x < y;
        end
    endfunction

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED time %0t: %s got 0x%08h expected 0x%08h",
                     $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reset_outputs();
        compare_value("o_retire", {31'd0, retire}, 32'd0);
        compare_value("o_halted", {31'd0, halted}, 32'd0);
        compare_value("o_pc", pc, RESET_PC);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stream generator with reference model
    //////////////////////////////////////////////////////////////////////

    task automatic issue_random();
        logic [31:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [15:0] imm;
        logic [25:0] jindex;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] pc4;
        logic [31:0] val;
        logic [31:0] next;
        logic [31:0] word;
        logic [4:0]  dest;
        logic        wr;
        int          kind;
        expect_t     e;
        r = rand_bits(21);
        rs = r[4:0];
        rt = r[9:5];
        rd = r[14:10];
        shamt = r[19:15];
        if (r[20])
        begin
            rs = {2'b00, rs[2:0]};  // Small register set for more dependencies.
            rt = {2'b00, rt[2:0]};
            rd = {2'b00, rd[2:0]};
        end
        // Link values are not forwarded.
        if (link_reg != 5'd0 && rs == link_reg)
        begin
            rs = rs ^ 5'd1;
        end
        if (link_reg != 5'd0 && rt == link_reg)
        begin
            rt = rt ^ 5'd1;
        end
        r = rand_bits(26);
        imm = r[15:0];
        jindex = r[25:0];
        r = rand_bits(5);
        kind = int'(r % 32'd22);
        a = model_regs[rs];
        b = model_regs[rt];
        sext = {{16{imm[15]}}, imm};
        zext = {16'd0, imm};
        pc4 = model_pc + 32'd4;
        val = 32'd0;
        dest = rd;
        wr = 1'b1;
        next = pc4;
        case (kind)
            0:
            begin
                word = {6'd0, rs, rt, rd, shamt, mips_isa_pkg::FN_SLL};
                val = b << shamt;
            end
            1:
            begin
                word = {6'd0, rs, rt, rd, shamt, mips_isa_pkg::FN_SRL};
                val = b >> shamt;
            end
            2:
            begin
                word = {6'd0, rs, rt, rd, shamt, mips_isa_pkg::FN_SRA};
                val = (b >> shamt) | ({32{b[31]}} & ~(32'hffff_ffff >> shamt));
            end
            3:
            begin
                word = {6'd0, rs, rt, rd, 5'd0, mips_isa_pkg::FN_ADDU};
                val = a + b;
            end
            4:
            begin
                word = {6'd0, rs, rt, rd, 5'd0, mips_isa_pkg::FN_SUBU};
                val = a - b;
            end
            5:
            begin
                word = {6'd0, rs, rt, rd, 5'd0, mips_isa_pkg::FN_AND};
                val = a & b;
            end
            6:
            begin
                word = {6'd0, rs, rt, rd, 5'd0, mips_isa_pkg::FN_OR};
                val = a | b;
            end
            7:
            begin
                word = {6'd0, rs, rt, rd, 5'd0, mips_isa_pkg::FN_XOR};
                val = a ^ b;
            end
            8:
            begin
                word = {6'd0, rs, rt, rd, 5'd0, mips_isa_pkg::FN_SLT};
                val = {31'd0, less_signed(a, b)};
            end
            9:
            begin
                word = {mips_isa_pkg::OP_ADDIU, rs, rt, imm};
                dest = rt;
                val = a + sext;
            end
            10:
            begin
                word = {mips_isa_pkg::OP_SLTI, rs, rt, imm};
                dest = rt;
                val = {31'd0, less_signed(a, sext)};
            end
            11:
            begin
                word = {mips_isa_pkg::OP_ANDI, rs, rt, imm};
                dest = rt;
                val = a & zext;
            end
            12:
            begin
                word = {mips_isa_pkg::OP_ORI, rs, rt, imm};
                dest = rt;
                val = a | zext;
            end
            13:
            begin
                word = {mips_isa_pkg::OP_LUI, 5'd0, rt, imm};
                dest = rt;
                val = {imm, 16'd0};
            end
            14:
            begin
                word = {6'd0, rs, 15'd0, mips_isa_pkg::FN_JR};
                wr = 1'b0;
                next = a;
            end
            15:
            begin
                word = {6'd0, rs, 5'd0, rd, 5'd0, mips_isa_pkg::FN_JALR};
                val = pc4;
                next = a;
            end
            16:
            begin
                word = {mips_isa_pkg::OP_BEQ, rs, rt, imm};
                wr = 1'b0;
                if (a == b)
                begin
                    next = pc4 + {sext[29:0], 2'b00};
                end
            end
            17:
            begin
                word = {mips_isa_pkg::OP_BNE, rs, rt, imm};
                wr = 1'b0;
                if (a != b)
                begin
                    next = pc4 + {sext[29:0], 2'b00};
                end
            end
            18:
            begin
                word = {mips_isa_pkg::OP_J, jindex};
                wr = 1'b0;
                next = {pc4[31:28], jindex, 2'b00};
            end
            19:
            begin
                word = {mips_isa_pkg::OP_JAL, jindex};
                dest = 5'd31;
                val = pc4;
                next = {pc4[31:28], jindex, 2'b00};
            end
            20:
            begin
                word = {2'b01, shamt[3:0], jindex};  // Unused opcode.
                wr = 1'b0;
            end
            default:
            begin
                word = {6'd0, rs, rt, rd, shamt, 2'b01, imm[3:0]};  // Unused function code.
                wr   = 1'b0;
            end
        endcase
        if (dest == 5'd0)
        begin
            wr = 1'b0;
        end
        e.info.pc      = model_pc;
        e.info.wr_en   = wr;
        e.info.wr_addr = wr ? dest : 5'd0;
        e.info.wr_data = wr ? val : 32'd0;
        e.next_pc      = next;
        e.halt         = 1'b0;
        expected.push_back(e);
        if (wr)
        begin
            model_regs[dest] = val;
        end
        model_pc = next;
        if ((kind == 15 || kind == 19) && wr)
        begin
            link_reg = dest;
        end
        else
        begin
            link_reg = 5'd0;
        end
        instr       <= word;
        instr_valid <= 1'b1;
    endtask

    task automatic issue_halt();
        expect_t e;
        e.info.pc      = model_pc;
        e.info.wr_en   = 1'b0;
        e.info.wr_addr = 5'd0;
        e.info.wr_data = 32'd0;
        e.next_pc      = model_pc + 32'd4;
        e.halt         = 1'b1;
        expected.push_back(e);
        model_pc = model_pc + 32'd4;
        instr       <= mips_isa_pkg::HALT_WORD;
        instr_valid <= 1'b1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequence, retire checker and timeout
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        instr_valid = 1'b0;
        instr       = 32'd0;
        link_reg    = 5'd0;
        for (idx = 0; idx < 32; idx++)
        begin
            model_regs[idx] = 32'd0;
        end
        model_pc = RESET_PC;
        @(posedge clk);
        repeat (2)
        begin
            @(negedge clk);
            check_reset_outputs();
        end
        wait (arst_n);
        @(negedge clk);
        check_reset_outputs();
        issued = 0;
        while (issued < NUM_INSTR)
        begin
            @(posedge clk);
            draw = rand_bits(2);
            if (draw[1:0] == 2'b00)
            begin
                instr_valid <= 1'b0;  // Idle cycle.
            end
            else
            begin
                issue_random();
                issued++;
            end
        end
        @(posedge clk);
        issue_halt();
        // Strobes after HALT must not retire.
        repeat (20)
        begin
            @(posedge clk);
            draw = rand_bits(32);
            instr       <= draw;
            instr_valid <= draw[0];
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        while (!halted)
        begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (expected.size() == 0)
        begin
            $display("Result: PASSED");
            $finish;
        end
        else
        begin
            $display("Run ended with %0d expected retires still outstanding", expected.size());
            abort_run();
        end
    end

    always @(negedge clk)
    begin
        if (arst_n && retire)
        begin
            if (expected.size() == 0)
            begin
                $display("Unexpected retire at time %0t with no instruction outstanding", $time);
                abort_run();
            end
            else
            begin
                head = expected.pop_front();
                compare_value("o_retire_info.pc", retire_info.pc, head.info.pc);
                compare_value("o_retire_info.wr_en", {31'd0, retire_info.wr_en},
                              {31'd0, head.info.wr_en});
                compare_value("o_retire_info.wr_addr", {27'd0, retire_info.wr_addr},
                              {27'd0, head.info.wr_addr});
                compare_value("o_retire_info.wr_data", retire_info.wr_data, head.info.wr_data);
                compare_value("o_pc", pc, head.next_pc);
                compare_value("o_halted", {31'd0, halted}, {31'd0, head.halt});
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- sources.f
verilog/mips_isa_pkg.sv
verilog/mips_pipe_pkg.sv
verilog/decoder.sv
verilog/execute_unit.sv
verilog/result_stage.sv
verilog/mips_core.sv
bench/clock_gen.sv
bench/mips_core_tb.sv

//--- Makefile
TOP := mips_core_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --top-module $(TOP) -f sources.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir
